// File: Bender.yml
package:
  name: posit_div_sqrt_cluster

dependencies: {}

sources:
  - positPkg.sv
  - positDecode.sv
  - positRound.sv
  - positDivSqrtLane.sv
  - positDispatch.sv
  - positCollect.sv
  - positDivSqrtCluster.sv

  - target: test
    files:
      - tbClkGen.sv
      - tbPositCluster.sv

// File: list.f
positPkg.sv
positDecode.sv
positRound.sv
positDivSqrtLane.sv
positDispatch.sv
positCollect.sv
positDivSqrtCluster.sv
tbClkGen.sv
tbPositCluster.sv

// File: positCollect.sv
`timescale 1ns/1ps

module positCollect import positPkg::*; #(
  parameter int unsigned NumLanes   = 4,
  parameter int unsigned PositWidth = positPkg::PositWidth,
  parameter type         TagType    = tagT
) (
  input  logic                  clk_i,
  input  logic                  rstN_i,
  input  logic [NumLanes-1:0]   laneDone_i,
  input  logic [PositWidth-1:0] laneResult_i [NumLanes],
  input  statusT                laneStatus_i [NumLanes],
  input  TagType                laneTag_i [NumLanes],
  output logic [NumLanes-1:0]   laneDrain_o,
  output logic                  outValid_o,
  input  logic                  outReady_i,
  output logic [PositWidth-1:0] result_o,
  output statusT                status_o,
  output TagType                tag_o
);

  localparam int unsigned PtrWidth = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic [PtrWidth-1:0] ptrQ;
  logic                xfer;

  // Pointed lane is shown as is, so a stall keeps it stable
  assign outValid_o = laneDone_i[ptrQ];
  assign result_o   = laneResult_i[ptrQ];
  assign status_o   = laneStatus_i[ptrQ];
  assign tag_o      = laneTag_i[ptrQ];

  assign xfer        = outValid_o & outReady_i;
  assign laneDrain_o = xfer ? (NumLanes'(1) << ptrQ) : '0;

  // Drain order follows dispatch order
  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      ptrQ <= '0;
    end else if (xfer) begin
      ptrQ <= (ptrQ == PtrWidth'(NumLanes - 1)) ? '0 : ptrQ + 1'b1;
    end
  end

  // ------------------------------
  // Downstream hold while stalled
  // ------------------------------
  assert property (@(posedge clk_i) disable iff (!rstN_i)
    outValid_o && !outReady_i |=>
      outValid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else $error("output changed during a stall");

endmodule

// File: positDecode.sv
`timescale 1ns/1ps

module positDecode import positPkg::*; #(
  parameter int unsigned PositWidth = positPkg::PositWidth,
  parameter int unsigned ExpBits    = positPkg::ExpBits,
  localparam int unsigned RegWidth  = regimeWidth(PositWidth),
  localparam int unsigned RunWidth  = RegWidth - 1,
  localparam int unsigned FracWidth = PositWidth - 1 - ExpBits
) (
  input  logic [PositWidth-1:0]      posit_i,
  output logic                       sign_o,
  output logic signed [RegWidth-1:0] regime_o,
  output logic [ExpBits-1:0]         exponent_o,
  output logic [PositWidth-1:0]      mantissa_o,
  output logic                       isNar_o,
  output logic                       isZero_o
);

  logic [PositWidth-1:0]        absVal;
  logic [PositWidth-2:0]        body;
  logic [PositWidth-2:0]        search;
  logic [PositWidth-2:0]        fields;
  logic                         regBit;
  logic [RunWidth-1:0]          run;
  logic signed [RegWidth-1:0]   runS;
  logic [RegWidth-1:0]          shiftAmt;

  assign sign_o   = posit_i[PositWidth-1];
  assign isZero_o = (posit_i == '0);
  assign isNar_o  = (posit_i == {1'b1, {(PositWidth-1){1'b0}}});

  // Fields are read from the magnitude
  assign absVal = sign_o ? -posit_i : posit_i;
  assign body   = absVal[PositWidth-2:0];
  assign regBit = body[PositWidth-2];
  assign search = regBit ? ~body : body;

  // Highest set bit of search ends the regime run
  always_comb begin
    run = RunWidth'(PositWidth - 1);
    for (int i = 0; i < PositWidth - 1; i++) begin
      if (search[i]) begin
        run = RunWidth'(PositWidth - 2 - i);
      end
    end
  end

  assign runS     = $signed(RegWidth'(run));
  assign regime_o = regBit ? (runS - RegWidth'(1)) : -runS;

  // Drop the run and its terminating bit
  assign shiftAmt   = RegWidth'(run) + RegWidth'(1);
  assign fields     = body << shiftAmt;
  assign exponent_o = fields[PositWidth-2 -: ExpBits];
  assign mantissa_o = PositWidth'({1'b1, fields[FracWidth-1:0]}) << ExpBits;

endmodule

// File: positDispatch.sv
`timescale 1ns/1ps

module positDispatch import positPkg::*; #(
  parameter int unsigned NumLanes   = 4,
  parameter int unsigned PositWidth = positPkg::PositWidth,
  parameter type         TagType    = tagT
) (
  input  logic                  clk_i,
  input  logic                  rstN_i,
  input  logic                  inValid_i,
  output logic                  inReady_o,
  input  logic [PositWidth-1:0] opA_i,
  input  logic [PositWidth-1:0] opB_i,
  input  opE                    op_i,
  input  TagType                tag_i,
  output logic [NumLanes-1:0]   laneStart_o,
  output logic [PositWidth-1:0] laneOpA_o,
  output logic [PositWidth-1:0] laneOpB_o,
  output opE                    laneOp_o,
  output TagType                laneTag_o,
  input  logic [NumLanes-1:0]   creditReturn_i,
  output logic                  busy_o
);

  localparam int unsigned PtrWidth = (NumLanes > 1) ? $clog2(NumLanes) : 1;

  logic [NumLanes-1:0] creditQ;
  logic [PtrWidth-1:0] ptrQ;
  logic                accept;

  // Only the pointed lane may take the request
  assign inReady_o   = creditQ[ptrQ];
  assign accept      = inValid_i & inReady_o;
  assign laneStart_o = accept ? (NumLanes'(1) << ptrQ) : '0;

  assign laneOpA_o = opA_i;
  assign laneOpB_o = opB_i;
  assign laneOp_o  = op_i;
  assign laneTag_o = tag_i;

  assign busy_o = ~&creditQ;

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      creditQ <= '1;
      ptrQ    <= '0;
    end else begin
      creditQ <= (creditQ & ~laneStart_o) | creditReturn_i;
      if (accept) begin
        ptrQ <= (ptrQ == PtrWidth'(NumLanes - 1)) ? '0 : ptrQ + 1'b1;
      end
    end
  end

  // Credit comes back only to a lane that gave it away
  assert property (@(posedge clk_i) disable iff (!rstN_i) (creditReturn_i & creditQ) == '0)
    else $error("credit returned to a lane that holds one");

endmodule

// File: positDivSqrtCluster.sv
`timescale 1ns/1ps

module positDivSqrtCluster import positPkg::*; #(
  parameter int unsigned PositWidth = positPkg::PositWidth,
  parameter int unsigned ExpBits    = positPkg::ExpBits,
  parameter int unsigned NumLanes   = 4,
  parameter type         TagType    = tagT
) (
  input  logic                  clk_i,
  input  logic                  rstN_i,
  input  logic                  inValid_i,
  output logic                  inReady_o,
  input  logic [PositWidth-1:0] opA_i,
  input  logic [PositWidth-1:0] opB_i,
  input  opE                    op_i,
  input  TagType                tag_i,
  output logic                  outValid_o,
  input  logic                  outReady_i,
  output logic [PositWidth-1:0] result_o,
  output statusT                status_o,
  output TagType                tag_o,
  output logic                  busy_o
);

  logic [NumLanes-1:0]   laneStart, laneDone, laneDrain;
  logic [PositWidth-1:0] laneOpA, laneOpB;
  opE                    laneOp;
  TagType                laneTagIn;
  logic [PositWidth-1:0] laneResult [NumLanes];
  statusT                laneStatus [NumLanes];
  TagType                laneTagOut [NumLanes];

  positDispatch #(.NumLanes(NumLanes), .PositWidth(PositWidth), .TagType(TagType)) dispatch (
    .clk_i, .rstN_i, .inValid_i, .inReady_o, .opA_i, .opB_i, .op_i, .tag_i,
    .laneStart_o(laneStart), .laneOpA_o(laneOpA), .laneOpB_o(laneOpB),
    .laneOp_o(laneOp), .laneTag_o(laneTagIn), .creditReturn_i(laneDrain), .busy_o
  );

  for (genvar i = 0; i < NumLanes; i++) begin : genLane
    positDivSqrtLane #(.PositWidth(PositWidth), .ExpBits(ExpBits), .TagType(TagType)) lane (
      .clk_i, .rstN_i, .start_i(laneStart[i]), .drain_i(laneDrain[i]),
      .opA_i(laneOpA), .opB_i(laneOpB), .op_i(laneOp), .tag_i(laneTagIn),
      .done_o(laneDone[i]), .result_o(laneResult[i]), .status_o(laneStatus[i]),
      .tag_o(laneTagOut[i])
    );
  end

  positCollect #(.NumLanes(NumLanes), .PositWidth(PositWidth), .TagType(TagType)) collect (
    .clk_i, .rstN_i, .laneDone_i(laneDone), .laneResult_i(laneResult),
    .laneStatus_i(laneStatus), .laneTag_i(laneTagOut), .laneDrain_o(laneDrain),
    .outValid_o, .outReady_i, .result_o, .status_o, .tag_o
  );

endmodule

// File: positDivSqrtLane.sv
`timescale 1ns/1ps

module positDivSqrtLane import positPkg::*; #(
  parameter int unsigned PositWidth = positPkg::PositWidth,
  parameter int unsigned ExpBits    = positPkg::ExpBits,
  parameter type         TagType    = tagT
) (
  input  logic                  clk_i,
  input  logic                  rstN_i,
  input  logic                  start_i,
  input  logic                  drain_i,
  input  logic [PositWidth-1:0] opA_i,
  input  logic [PositWidth-1:0] opB_i,
  input  opE                    op_i,
  input  TagType                tag_i,
  output logic                  done_o,
  output logic [PositWidth-1:0] result_o,
  output statusT                status_o,
  output TagType                tag_o
);

  localparam int unsigned RegWidth   = regimeWidth(PositWidth);
  localparam int unsigned ScaleWidth = RegWidth + ExpBits + 2;
  localparam int unsigned RemWidth   = PositWidth + 3;
  localparam int unsigned CntWidth   = $clog2(PositWidth);
  localparam logic [PositWidth-1:0] NarPattern = {1'b1, {(PositWidth-1){1'b0}}};

  typedef enum logic [2:0] {StIdle, StDecode, StIter, StRound, StDone} stateE;

  stateE                        stateQ;
  logic [CntWidth-1:0]          cntQ;
  logic [PositWidth-1:0]        opAQ, opBQ;
  opE                           opQ;
  TagType                       tagQ;
  logic                         signA, signB, narA, narB, zeroA, zeroB;
  logic signed [RegWidth-1:0]   regA, regB;
  logic [ExpBits-1:0]           expA, expB;
  logic [PositWidth-1:0]        mantA, mantB;
  logic signed [ScaleWidth-1:0] scaleA, scaleB;
  logic                         special, nvFlag, dzFlag;
  logic [PositWidth-1:0]        specResult;
  logic [RemWidth-1:0]          remQ, remShift, trial, diff, remSel, remNext;
  logic [PositWidth-1:0]        quotQ, divisorQ;
  logic [2*PositWidth-1:0]      radQ;
  logic                         qBit;
  logic                         signQ;
  logic signed [ScaleWidth-1:0] scaleQ;
  logic                         specialQ;
  logic [PositWidth-1:0]        specResultQ;
  statusT                       specStatusQ;
  logic [2*PositWidth-1:0]      roundMant;
  logic signed [ScaleWidth-1:0] roundScale;
  logic [PositWidth-1:0]        rounded;
  logic                         inexact;
  logic [PositWidth-1:0]        resultQ;
  statusT                       statusQ;

  positDecode #(.PositWidth(PositWidth), .ExpBits(ExpBits)) decA (
    .posit_i(opAQ), .sign_o(signA), .regime_o(regA), .exponent_o(expA),
    .mantissa_o(mantA), .isNar_o(narA), .isZero_o(zeroA)
  );

  positDecode #(.PositWidth(PositWidth), .ExpBits(ExpBits)) decB (
    .posit_i(opBQ), .sign_o(signB), .regime_o(regB), .exponent_o(expB),
    .mantissa_o(mantB), .isNar_o(narB), .isZero_o(zeroB)
  );

  assign scaleA = ScaleWidth'($signed({regA, expA}));
  assign scaleB = ScaleWidth'($signed({regB, expB}));

  // Special operands, checked in priority order
  always_comb begin
    special    = 1'b1;
    nvFlag     = 1'b0;
    dzFlag     = 1'b0;
    specResult = NarPattern;
    if (narA || (opQ == OpDiv && narB)) begin
      nvFlag = 1'b1;
    end else if (opQ == OpDiv && zeroB) begin
      dzFlag = 1'b1;
    end else if (opQ == OpSqrt && signA) begin
      nvFlag = 1'b1;
    end else if (zeroA) begin
      specResult = '0;
    end else begin
      special = 1'b0;
    end
  end

  // ------------------------------
  // Restoring recurrence step
  // ------------------------------
  always_comb begin
    if (opQ == OpDiv) begin
      trial    = RemWidth'(divisorQ);
      remShift = remQ;
    end else begin
      trial    = RemWidth'({quotQ, 2'b01});
      remShift = {remQ[RemWidth-3:0], radQ[2*PositWidth-1 -: 2]};
    end
    diff    = remShift - trial;
    qBit    = ~diff[RemWidth-1];
    remSel  = qBit ? diff : remShift;
    remNext = (opQ == OpDiv) ? (remSel << 1) : remSel;
  end

  // Quotient below one needs one more normalizing shift
  always_comb begin
    if (opQ == OpDiv && !quotQ[PositWidth-1]) begin
      roundMant  = {quotQ[PositWidth-2:0], {(PositWidth+1){1'b0}}};
      roundScale = scaleQ - ScaleWidth'(1);
    end else begin
      roundMant  = {quotQ, {PositWidth{1'b0}}};
      roundScale = scaleQ;
    end
  end

  positRound #(.PositWidth(PositWidth), .ExpBits(ExpBits)) rnd (
    .sign_i(signQ), .scale_i(roundScale), .mantissa_i(roundMant),
    .sticky_i(remQ != '0), .result_o(rounded), .inexact_o(inexact)
  );

  always_ff @(posedge clk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      stateQ <= StIdle;
      cntQ   <= '0;
    end else begin
      case (stateQ)
        StIdle: begin
          if (start_i) begin
            stateQ <= StDecode;
          end
        end
        StDecode: begin
          stateQ <= StIter;
          cntQ   <= '0;
        end
        StIter: begin
          cntQ <= cntQ + 1'b1;
          if (cntQ == CntWidth'(PositWidth - 1)) begin
            stateQ <= StRound;
          end
        end
        StRound: stateQ <= StDone;
        StDone: begin
          if (drain_i) begin
            stateQ <= StIdle;
          end
        end
        default: stateQ <= StIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    case (stateQ)
      StIdle: begin
        if (start_i) begin
          opAQ <= opA_i;
          opBQ <= opB_i;
          opQ  <= op_i;
          tagQ <= tag_i;
        end
      end
      StDecode: begin
        signQ       <= (opQ == OpDiv) & (signA ^ signB);
        scaleQ      <= (opQ == OpDiv) ? (scaleA - scaleB) : (scaleA >>> 1);
        remQ        <= (opQ == OpDiv) ? RemWidth'(mantA) : '0;
        divisorQ    <= mantB;
        quotQ       <= '0;
        // Odd scale moves one bit into the radicand
        radQ        <= scaleA[0] ? {mantA, {PositWidth{1'b0}}}
                                 : {1'b0, mantA, {(PositWidth-1){1'b0}}};
        specialQ    <= special;
        specResultQ <= specResult;
        specStatusQ <= statusT'{nv: nvFlag, dz: dzFlag, nx: 1'b0};
      end
      StIter: begin
        remQ  <= remNext;
        quotQ <= {quotQ[PositWidth-2:0], qBit};
        radQ  <= {radQ[2*PositWidth-3:0], 2'b00};
      end
      StRound: begin
        resultQ <= specialQ ? specResultQ : rounded;
        statusQ <= specialQ ? specStatusQ : statusT'{nv: 1'b0, dz: 1'b0, nx: inexact};
      end
      default: ;
    endcase
  end

  assign done_o   = (stateQ == StDone);
  assign result_o = resultQ;
  assign status_o = statusQ;
  assign tag_o    = tagQ;

  // Credit protocol seen from the lane
  assert property (@(posedge clk_i) disable iff (!rstN_i) start_i |-> stateQ == StIdle)
    else $error("start on an occupied lane");
  assert property (@(posedge clk_i) disable iff (!rstN_i) drain_i |-> done_o)
    else $error("drain on a lane without a result");

endmodule

// File: positPkg.sv
package positPkg;

  // ------------------------------
  // Posit format
  // ------------------------------
  localparam int unsigned PositWidth = 16;
  localparam int unsigned ExpBits    = 1;

  // Signed regime range, run lengths reach PositWidth-1
  function automatic int unsigned regimeWidth(input int unsigned width);
    return $clog2(width) + 1;
  endfunction

  // ------------------------------
  // Operations, flags, tags
  // ------------------------------
  typedef enum logic {
    OpDiv  = 1'b0,
    OpSqrt = 1'b1
  } opE;

  // Invalid, divide by zero, inexact
  typedef struct packed {
    logic nv;
    logic dz;
    logic nx;
  } statusT;

  typedef logic [7:0] tagT;

endpackage

// File: positRound.sv
`timescale 1ns/1ps

module positRound import positPkg::*; #(
  parameter int unsigned PositWidth = positPkg::PositWidth,
  parameter int unsigned ExpBits    = positPkg::ExpBits,
  localparam int unsigned RegWidth   = regimeWidth(PositWidth),
  localparam int unsigned ScaleWidth = RegWidth + ExpBits + 2
) (
  input  logic                         sign_i,
  input  logic signed [ScaleWidth-1:0] scale_i,
  input  logic [2*PositWidth-1:0]      mantissa_i,
  input  logic                         sticky_i,
  output logic [PositWidth-1:0]        result_o,
  output logic                         inexact_o
);

  localparam int unsigned ExtWidth  = 3 * PositWidth + ExpBits;
  localparam int          MaxRegime = PositWidth - 2;

  logic signed [ScaleWidth-1:0] regime;
  logic [ExpBits-1:0]           expField;
  logic                         regPos;
  logic                         satHigh;
  logic                         satLow;
  logic [RegWidth-1:0]          shiftAmt;
  logic [ExtWidth-1:0]          ext;
  logic [ExtWidth-1:0]          shifted;
  logic [PositWidth-2:0]        body;
  logic [PositWidth-2:0]        rounded;
  logic [PositWidth-2:0]        mag;
  logic                         guard;
  logic                         stickyAll;
  logic                         roundUp;

  assign regime   = scale_i >>> ExpBits;
  assign expField = scale_i[ExpBits-1:0];
  assign regPos   = ~regime[ScaleWidth-1];
  assign satHigh  = (regime > MaxRegime);
  assign satLow   = (regime < -MaxRegime);

  // Two-bit regime seed, widened by an arithmetic shift
  assign shiftAmt = regPos ? RegWidth'(regime) : RegWidth'(-regime - 1);
  assign ext      = {regPos, ~regPos, expField, mantissa_i[2*PositWidth-2:0],
                     {(PositWidth-1){1'b0}}};
  assign shifted  = $signed(ext) >>> shiftAmt;

  // ------------------------------
  // Round to nearest even
  // ------------------------------
  assign body      = shifted[ExtWidth-1 -: PositWidth-1];
  assign guard     = shifted[ExtWidth-PositWidth];
  assign stickyAll = (|shifted[ExtWidth-PositWidth-1:0]) | sticky_i;
  // Maxpos holds instead of wrapping to zero
  assign roundUp   = guard & (body[0] | stickyAll) & ~(&body);
  assign rounded   = body + (PositWidth-1)'(roundUp);

  // Out of range scales clamp to maxpos or minpos
  always_comb begin
    if (satHigh) begin
      mag = {(PositWidth-1){1'b1}};
    end else if (satLow) begin
      mag = (PositWidth-1)'(1);
    end else begin
      mag = rounded;
    end
  end

  assign inexact_o = satHigh | satLow | guard | stickyAll;
  assign result_o  = sign_i ? -{1'b0, mag} : {1'b0, mag};

endmodule

// File: tbClkGen.sv
`timescale 1ns/1ps

module tbClkGen #(
  parameter real         PeriodNs    = 4.0,
  parameter int unsigned ResetCycles = 5
) (
  output logic clk_o,
  output logic rstN_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2.0) clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rstN_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rstN_o <= 1'b1;
  end

endmodule

// File: tbPositCluster.sv
`timescale 1ns/1ps

module tbPositCluster import positPkg::*; ();

  localparam int unsigned Width      = positPkg::PositWidth;
  localparam int          Latency    = Width + 2;
  localparam int          WaitLimit  = 400;
  localparam int          MaxVectors = 32;
  localparam statusT      Clear      = statusT'(3'b000);
  localparam statusT      Nx         = statusT'(3'b001);
  localparam statusT      Dz         = statusT'(3'b010);
  localparam statusT      Nv         = statusT'(3'b100);

  typedef struct packed {
    opE               op;
    logic [Width-1:0] opA;
    logic [Width-1:0] opB;
    logic [Width-1:0] result;
    statusT           status;
  } vectorT;

  logic             clk, rstN;
  logic             inValid, inReady, outValid, busy;
  logic             outReady = 1'b1;
  logic [Width-1:0] opA, opB, result;
  opE               op;
  tagT              tag, tagOut;
  statusT           status;

  vectorT vectors [MaxVectors];
  int     vecCount;
  int     pendingIdx [$];
  int     receivedCount;
  int     valueErrors, protocolErrors, timeoutCount;
  bit     randomReady, sawNotReady;
  integer seed = 32'h35a6;

  tbClkGen clkGen (.clk_o(clk), .rstN_o(rstN));

  positDivSqrtCluster dut_i (
    .clk_i(clk), .rstN_i(rstN), .inValid_i(inValid), .inReady_o(inReady),
    .opA_i(opA), .opB_i(opB), .op_i(op), .tag_i(tag),
    .outValid_o(outValid), .outReady_i(outReady), .result_o(result),
    .status_o(status), .tag_o(tagOut), .busy_o(busy)
  );

  // ------------------------------
  // Stimulus and expected values
  // ------------------------------
  task automatic addVector(input opE o, input logic [Width-1:0] a, input logic [Width-1:0] b,
                           input logic [Width-1:0] r, input statusT s);
    vectors[vecCount] = '{op: o, opA: a, opB: b, result: r, status: s};
    vecCount++;
  endtask

  task automatic loadTable();
    // Exact quotients and roots
    addVector(OpDiv,  16'h6000, 16'h5000, 16'h5000, Clear);
    addVector(OpDiv,  16'h4000, 16'h4000, 16'h4000, Clear);
    addVector(OpDiv,  16'hA800, 16'h4800, 16'hB000, Clear);
    addVector(OpDiv,  16'h3000, 16'h6000, 16'h1800, Clear);
    addVector(OpDiv,  16'h5800, 16'hA800, 16'hC000, Clear);
    addVector(OpSqrt, 16'h6000, 16'h0000, 16'h5000, Clear);
    addVector(OpSqrt, 16'h2000, 16'h0000, 16'h3000, Clear);
    addVector(OpSqrt, 16'h7000, 16'h0000, 16'h6000, Clear);
    // 1/3, 2/3, sqrt 2, sqrt 3
    addVector(OpDiv,  16'h4000, 16'h5800, 16'h2555, Nx);
    addVector(OpDiv,  16'h5000, 16'h5800, 16'h3555, Nx);
    addVector(OpSqrt, 16'h5000, 16'h0000, 16'h46A1, Nx);
    addVector(OpSqrt, 16'h5800, 16'h0000, 16'h4BB6, Nx);
    // Special operands
    addVector(OpDiv,  16'h4000, 16'h0000, 16'h8000, Dz);
    addVector(OpSqrt, 16'hA000, 16'h0000, 16'h8000, Nv);
    addVector(OpDiv,  16'h8000, 16'h4000, 16'h8000, Nv);
    addVector(OpDiv,  16'h4000, 16'h8000, 16'h8000, Nv);
    addVector(OpSqrt, 16'h8000, 16'h0000, 16'h8000, Nv);
    addVector(OpDiv,  16'h0000, 16'h5000, 16'h0000, Clear);
    addVector(OpSqrt, 16'h0000, 16'h0000, 16'h0000, Clear);
  endtask

  task automatic driveVector(input int idx);
    inValid <= 1'b1;
    op      <= vectors[idx].op;
    opA     <= vectors[idx].opA;
    opB     <= vectors[idx].opB;
    tag     <= tagT'(idx);
  endtask

  task automatic compareResult(input logic [Width-1:0] got, input logic [Width-1:0] exp,
                               input int idx);
    if (got !== exp) begin
      $display("[ERROR] %t: entry %0d result %h, expected %h", $time, idx, got, exp);
      valueErrors++;
    end
  endtask

  task automatic compareStatus(input statusT got, input statusT exp, input int idx);
    if (got !== exp) begin
      $display("[ERROR] %t: entry %0d status nv/dz/nx %b, expected %b", $time, idx, got, exp);
      valueErrors++;
    end
  endtask

  task automatic compareTag(input tagT got, input tagT exp, input int idx);
    if (got !== exp) begin
      $display("[ERROR] %t: entry %0d tag %h, expected %h", $time, idx, got, exp);
      valueErrors++;
    end
  endtask

  task automatic compareFlag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("[ERROR] %t: %s is %b, expected %b", $time, name, got, exp);
      valueErrors++;
    end
  endtask

  // ------------------------------
  // Waits, each with a limit
  // ------------------------------
  task automatic waitReset(output bit ok);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!rstN && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    ok = rstN;
    if (!ok) begin
      $display("Timeout: reset was never released");
      timeoutCount++;
    end
  endtask

  task automatic waitDrained(output bit ok);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (pendingIdx.size() != 0 && cycles < WaitLimit) begin
      @(posedge clk);
      cycles++;
    end
    ok = (pendingIdx.size() == 0);
    if (!ok) begin
      $display("Timeout: %0d results never arrived", pendingIdx.size());
      timeoutCount++;
    end
  endtask

  task automatic checkLatency(output bit ok);
    int cycles;
    cycles = 0;
    @(posedge clk);
    driveVector(0);
    @(negedge clk);
    ok = inReady;
    if (!ok) begin
      $display("The idle DUT did not accept the latency request");
      protocolErrors++;
    end
    @(posedge clk);
    inValid <= 1'b0;
    if (ok) begin
      @(negedge clk);
      while (!outValid && cycles < WaitLimit) begin
        @(negedge clk);
        cycles++;
      end
      if (!outValid) begin
        $display("Timeout: no result for the latency request");
        timeoutCount++;
        ok = 1'b0;
      end else if (cycles != Latency) begin
        $display("[ERROR] %t: latency %0d cycles, expected %0d", $time, cycles, Latency);
        valueErrors++;
      end
    end
  endtask

  task automatic sendTable(output bit ok);
    int i;
    int cycles;
    ok = 1'b1;
    i  = 0;
    @(posedge clk);
    while (ok && i < vecCount) begin
      driveVector(i);
      cycles = 0;
      @(negedge clk);
      while (!inReady && cycles < WaitLimit) begin
        @(negedge clk);
        cycles++;
      end
      if (!inReady) begin
        $display("Timeout: entry %0d was never accepted", i);
        timeoutCount++;
        ok = 1'b0;
      end
      @(posedge clk);
      i++;
    end
    inValid <= 1'b0;
  endtask

  always @(posedge clk) begin
    if (randomReady) begin
      outReady <= 1'($random(seed));
    end else begin
      outReady <= 1'b1;
    end
  end

  // Handshakes seen at the falling edge complete on the next rising edge
  always @(negedge clk) begin : monitor
    int idx;
    if (rstN) begin
      if (!inReady) begin
        if (randomReady) begin
          sawNotReady = 1'b1;
        end
        if (pendingIdx.size() == 0) begin
          $display("[ERROR] %t: inReady_o low with no request outstanding", $time);
          protocolErrors++;
        end
      end
      if (busy !== (pendingIdx.size() != 0)) begin
        $display("[ERROR] %t: busy_o is %b with %0d requests outstanding",
                 $time, busy, pendingIdx.size());
        protocolErrors++;
      end
      if (outValid && outReady) begin
        if (pendingIdx.size() == 0) begin
          $display("A result left the DUT with no request outstanding");
          protocolErrors++;
        end else begin
          idx = pendingIdx.pop_front();
          compareResult(result, vectors[idx].result, idx);
          compareStatus(status, vectors[idx].status, idx);
          compareTag(tagOut, tagT'(idx), idx);
        end
        receivedCount++;
      end
      if (inValid && inReady) begin
        pendingIdx.push_back(int'(tag));
      end
    end
  end

  initial begin : mainSeq
    bit ok;
    $timeformat(-9, 1, " ns", 8);
    inValid = 1'b0;
    opA     = '0;
    opB     = '0;
    op      = OpDiv;
    tag     = '0;
    loadTable();
    waitReset(ok);
    if (ok) begin
      compareFlag(inReady, 1'b1, "inReady_o after reset");
      compareFlag(outValid, 1'b0, "outValid_o after reset");
      compareFlag(busy, 1'b0, "busy_o after reset");
      checkLatency(ok);
    end
    if (ok) waitDrained(ok);
    if (ok) sendTable(ok);
    if (ok) waitDrained(ok);
    // Same table again under random back-pressure
    if (ok) begin
      @(negedge clk);
      randomReady = 1'b1;
      sendTable(ok);
    end
    if (ok) waitDrained(ok);
    if (ok) begin
      if (!sawNotReady) begin
        $display("inReady_o never fell under back-pressure");
        protocolErrors++;
      end
      if (receivedCount != 1 + 2 * vecCount) begin
        $display("%0d results received, %0d expected", receivedCount, 1 + 2 * vecCount);
        protocolErrors++;
      end
    end
    $display("Errors: %0d value, %0d protocol, %0d timeout",
             valueErrors, protocolErrors, timeoutCount);
    if (valueErrors + protocolErrors + timeoutCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
